// ==== loongCsr.f ====
hw/csrPkg.sv
hw/trapIf.sv
hw/privCtrl.sv
hw/excCtrl.sv
hw/stableTimer.sv
hw/saveRegs.sv
hw/csrReadMux.sv
hw/csrTop.sv
test/csrChecker.sv
test/csrTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module csrTb -f loongCsr.f -o csrSim
./obj_dir/csrSim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// ==== test/csrTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrTb;
    import csrPkg::*;

    localparam logic [2:0] OpWrite = 3'd0;
    localparam logic [2:0] OpRead  = 3'd1;
    localparam logic [2:0] OpTrap  = 3'd2;
    localparam logic [2:0] OpRet   = 3'd3;
    localparam logic [2:0] OpIrq   = 3'd4;
    localparam logic [2:0] OpWait  = 3'd5;
    localparam logic [2:0] OpPoll  = 3'd6;

    // one bit per watched output in csrChecker order
    localparam logic [4:0] ChkNone   = 5'b00000;
    localparam logic [4:0] ChkRdata  = 5'b00001;
    localparam logic [4:0] ChkIrq    = 5'b00010;
    localparam logic [4:0] ChkPlv    = 5'b00100;
    localparam logic [4:0] ChkEra    = 5'b01000;
    localparam logic [4:0] ChkEentry = 5'b10000;

    // trap steps carry {esub, ecode} in exp
    // poll steps carry a timeout in cycles
    typedef struct packed {
        logic [2:0] op;
        csrAddrT    addr;
        dataT       val;
        logic [4:0] chk;
        dataT       exp;
        int         cycles;
    } stepT;

    logic       Clk;
    logic       rst;
    logic       wEn;
    csrAddrT    wAddr;
    dataT       wData;
    logic       rEn;
    csrAddrT    rAddr;
    dataT       rData;
    logic       trapValid;
    logic       trapReturn;
    dataT       trapPc;
    ecodeT      trapEcode;
    esubT       trapEsub;
    hwIrqT      hwIrq;
    logic       irqReq;
    dataT       eraOut;
    dataT       eentryOut;
    plvT        plv;
    logic [4:0] chkMask;
    dataT       expVal;
    int         errCount;
    int         checkCount;
    int         timeouts;
    stepT       stim [$];

    always #50 Clk = ~Clk;

    csrTop u_csrTop (.*);

    csrChecker u_csrChecker (.*);

    task automatic buildTable();
        // reset values
        stim.push_back('{OpRead, AddrCrmd, 32'h0, ChkRdata, 32'h8, 1});
        stim.push_back('{OpRead, AddrPrmd, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, AddrEcfg, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, AddrEstat, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, AddrEra, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, AddrEentry, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, AddrTid, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, AddrTcfg, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, AddrTval, 32'h0, ChkRdata, 32'h0, 1});
        for (int i = 0; i < DefNumSave; i++) begin
            stim.push_back('{OpRead, csrAddrT'(AddrSave0 + i), 32'h0, ChkRdata, 32'h0, 1});
        end
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkPlv, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkEentry, 32'h0, 1});

        // write and read back
        stim.push_back('{OpWrite, AddrEcfg, 32'hfff0_1234, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrEcfg, 32'h0, ChkRdata, 32'h0000_1234, 1});
        stim.push_back('{OpWrite, AddrEentry, 32'h1c00_0abc, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrEentry, 32'h0, ChkRdata, 32'h1c00_0a80, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkEentry, 32'h1c00_0a80, 1});
        stim.push_back('{OpWrite, AddrEra, 32'h8000_0040, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrEra, 32'h0, ChkRdata, 32'h8000_0040, 1});
        stim.push_back('{OpWrite, AddrTid, 32'h1234_5678, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrTid, 32'h0, ChkRdata, 32'h1234_5678, 1});
        stim.push_back('{OpWrite, AddrPrmd, 32'hffff_fffe, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrPrmd, 32'h0, ChkRdata, 32'h6, 1});
        stim.push_back('{OpWrite, AddrCrmd, 32'hf, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrCrmd, 32'h0, ChkRdata, 32'hf, 1});
        stim.push_back('{OpRead, AddrTiclr, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpRead, 14'h7ff, 32'h0, ChkRdata, 32'h0, 1});
        for (int i = 0; i < DefNumSave; i++) begin
            stim.push_back('{OpWrite, csrAddrT'(AddrSave0 + i),
                             32'h1111_1111 * dataT'(i + 1), ChkNone, 32'h0, 1});
        end
        for (int i = 0; i < DefNumSave; i++) begin
            stim.push_back('{OpRead, csrAddrT'(AddrSave0 + i), 32'h0, ChkRdata,
                             32'h1111_1111 * dataT'(i + 1), 1});
        end
        // first address past the bank must not alias a filled slot
        stim.push_back('{OpRead, csrAddrT'(AddrSave0 + DefNumSave), 32'h0, ChkRdata, 32'h0, 1});
        // rEn low reads zero
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkEra, 32'h8000_0040, 1});

        // trap entry from plv 3 with ie set and the ertn after it
        stim.push_back('{OpTrap, AddrCrmd, 32'h1c00_1000, ChkNone, 32'h0000_014b, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkPlv, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkEra, 32'h1c00_1000, 1});
        stim.push_back('{OpRead, AddrCrmd, 32'h0, ChkRdata, 32'h8, 1});
        stim.push_back('{OpRead, AddrPrmd, 32'h0, ChkRdata, 32'h7, 1});
        stim.push_back('{OpRead, AddrEstat, 32'h0, ChkRdata, 32'h014b_0000, 1});
        stim.push_back('{OpRet, AddrCrmd, 32'h0, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkPlv, 32'h3, 1});
        stim.push_back('{OpRead, AddrCrmd, 32'h0, ChkRdata, 32'hf, 1});

        // hardware line 0 lands in IS bit 2
        stim.push_back('{OpWrite, AddrEcfg, 32'h4, ChkNone, 32'h0, 1});
        stim.push_back('{OpIrq, AddrCrmd, 32'h1, ChkIrq, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h1, 1});
        stim.push_back('{OpRead, AddrEstat, 32'h0, ChkRdata, 32'h014b_0004, 1});
        stim.push_back('{OpWrite, AddrCrmd, 32'hb, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h0, 1});
        stim.push_back('{OpWrite, AddrCrmd, 32'hf, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h1, 1});
        stim.push_back('{OpWrite, AddrEcfg, 32'h0, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h0, 1});
        stim.push_back('{OpIrq, AddrCrmd, 32'h0, ChkNone, 32'h0, 1});

        // software bit 1
        stim.push_back('{OpWrite, AddrEcfg, 32'h2, ChkNone, 32'h0, 1});
        stim.push_back('{OpWrite, AddrEstat, 32'h2, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h1, 1});
        stim.push_back('{OpRead, AddrEstat, 32'h0, ChkRdata, 32'h014b_0002, 1});
        stim.push_back('{OpWrite, AddrEstat, 32'h0, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h0, 1});

        // one-shot with InitVal 3 expires after 12 edges
        stim.push_back('{OpWrite, AddrEcfg, 32'h800, ChkNone, 32'h0, 1});
        stim.push_back('{OpWrite, AddrTcfg, 32'hd, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrTval, 32'h0, ChkRdata, 32'hc, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h0, 11});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h1, 1});
        stim.push_back('{OpRead, AddrEstat, 32'h0, ChkRdata, 32'h014b_0800, 1});
        stim.push_back('{OpRead, AddrTval, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkNone, 32'h0, 3});
        stim.push_back('{OpRead, AddrTval, 32'h0, ChkRdata, 32'h0, 1});
        stim.push_back('{OpWrite, AddrTiclr, 32'h1, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h0, 1});

        // periodic mode polls the first expiry and times the second exactly
        stim.push_back('{OpWrite, AddrTcfg, 32'hf, ChkNone, 32'h0, 1});
        stim.push_back('{OpPoll, AddrCrmd, 32'h0, ChkNone, 32'h0, 40});
        stim.push_back('{OpWrite, AddrTiclr, 32'h1, ChkNone, 32'h0, 1});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h0, 10});
        stim.push_back('{OpWait, AddrCrmd, 32'h0, ChkIrq, 32'h1, 1});
        stim.push_back('{OpWrite, AddrTcfg, 32'h0, ChkNone, 32'h0, 1});
        stim.push_back('{OpRead, AddrTval, 32'h0, ChkRdata, 32'h0, 1});
    endtask

    task automatic waitIrqRise(input int limit);
        int n;
        n = 0;
        @(negedge Clk);
        while ((irqReq !== 1'b1) && (n < limit)) begin
            @(negedge Clk);
            n++;
        end
        if (irqReq !== 1'b1) begin
            $display("timeout: irqReq did not rise within %0d cycles at %0t", limit, $time);
            timeouts++;
        end
    endtask

    task automatic runStep(input stepT s);
        int n;
        @(posedge Clk);
        wEn        <= 1'b0;
        rEn        <= 1'b0;
        trapValid  <= 1'b0;
        trapReturn <= 1'b0;
        chkMask    <= ChkNone;
        rAddr      <= s.addr;
        case (s.op)
            OpWrite: begin
                wEn   <= 1'b1;
                wAddr <= s.addr;
                wData <= s.val;
            end
            OpRead: begin
                rEn <= 1'b1;
            end
            OpTrap: begin
                trapValid <= 1'b1;
                trapPc    <= s.val;
                trapEcode <= s.exp[5:0];
                trapEsub  <= s.exp[14:6];
            end
            OpRet: begin
                trapValid  <= 1'b1;
                trapReturn <= 1'b1;
            end
            OpIrq: begin
                hwIrq <= s.val[7:0];
            end
            default: begin
            end
        endcase
        // check lands in the last cycle of a wait step
        for (n = 1; (s.op == OpWait) && (n < s.cycles); n++) begin
            @(posedge Clk);
        end
        chkMask <= s.chk;
        expVal  <= s.exp;
        if (s.op == OpPoll) begin
            waitIrqRise(s.cycles);
        end
    endtask

    initial begin
        Clk        = 1'b0;
        rst        = 1'b1;
        wEn        = 1'b0;
        wAddr      = '0;
        wData      = '0;
        rEn        = 1'b0;
        rAddr      = '0;
        trapValid  = 1'b0;
        trapReturn = 1'b0;
        trapPc     = '0;
        trapEcode  = '0;
        trapEsub   = '0;
        hwIrq      = '0;
        chkMask    = ChkNone;
        expVal     = '0;
        timeouts   = 0;
        buildTable();
        repeat (5) @(posedge Clk);
        rst <= 1'b0;
        foreach (stim[i]) begin
            runStep(stim[i]);
        end
        @(posedge Clk);
        chkMask <= ChkNone;
        wEn     <= 1'b0;
        rEn     <= 1'b0;
        @(posedge Clk);
        $display("%0d checks, %0d value errors, %0d timeouts", checkCount, errCount, timeouts);
        if ((errCount == 0) && (timeouts == 0) && (checkCount > 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (1000) @(posedge Clk);
        $display("watchdog expired before the stimulus table completed");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/csrChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrChecker (
    input  logic         Clk,
    input  logic [4:0]   chkMask,
    input  csrPkg::dataT expVal,
    input  csrPkg::dataT rData,
    input  logic         irqReq,
    input  csrPkg::plvT  plv,
    input  csrPkg::dataT eraOut,
    input  csrPkg::dataT eentryOut,
    output int           errCount,
    output int           checkCount
);
    import csrPkg::*;

    int errors = 0;
    int checks = 0;

    assign errCount   = errors;
    assign checkCount = checks;

    task automatic compareValue(input string name, input dataT got, input dataT want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, want);
        end
    endtask

    // mask bits in order rData irqReq plv eraOut eentryOut
    // outputs have settled by the falling edge
    always @(negedge Clk) begin
        if (chkMask[0]) begin
            compareValue("rData", rData, expVal);
        end
        if (chkMask[1]) begin
            compareValue("irqReq", dataT'(irqReq), dataT'(expVal[0]));
        end
        if (chkMask[2]) begin
            compareValue("plv", dataT'(plv), dataT'(expVal[1:0]));
        end
        if (chkMask[3]) begin
            compareValue("eraOut", eraOut, expVal);
        end
        if (chkMask[4]) begin
            compareValue("eentryOut", eentryOut, expVal);
        end
    end

endmodule

`default_nettype wire

// ==== hw/csrTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrTop (
    input  logic             Clk,
    input  logic             rst,
    input  logic             wEn,
    input  csrPkg::csrAddrT  wAddr,
    input  csrPkg::dataT     wData,
    input  logic             rEn,
    input  csrPkg::csrAddrT  rAddr,
    output csrPkg::dataT     rData,
    input  logic             trapValid,
    input  logic             trapReturn,
    input  csrPkg::dataT     trapPc,
    input  csrPkg::ecodeT    trapEcode,
    input  csrPkg::esubT     trapEsub,
    input  csrPkg::hwIrqT    hwIrq,
    output logic             irqReq,
    output csrPkg::dataT     eraOut,
    output csrPkg::dataT     eentryOut,
    output csrPkg::plvT      plv
);
    import csrPkg::*;

    localparam int NumSave = DefNumSave;

    dataT crmd;
    dataT prmd;
    dataT ecfg;
    dataT estat;
    dataT tid;
    dataT tcfg;
    dataT tval;
    dataT saveVals [NumSave];
    logic timerPend;

    trapIf trap ();

    assign trap.valid    = trapValid;
    assign trap.isReturn = trapReturn;
    assign trap.pc       = trapPc;
    assign trap.ecode    = trapEcode;
    assign trap.esub     = trapEsub;

    assign plv = crmd[CrmdPlvHi:CrmdPlvLo];

    privCtrl u_privCtrl (
        .Clk(Clk), .rst(rst), .wEn(wEn), .wAddr(wAddr), .wData(wData),
        .trap(trap), .crmd(crmd), .prmd(prmd)
    );

    excCtrl u_excCtrl (
        .Clk(Clk), .rst(rst), .wEn(wEn), .wAddr(wAddr), .wData(wData),
        .trap(trap), .hwIrq(hwIrq), .timerPend(timerPend), .ie(crmd[CrmdIe]),
        .ecfg(ecfg), .estat(estat), .era(eraOut), .eentry(eentryOut), .irqReq(irqReq)
    );

    stableTimer u_stableTimer (
        .Clk(Clk), .rst(rst), .wEn(wEn), .wAddr(wAddr), .wData(wData),
        .tid(tid), .tcfg(tcfg), .tval(tval), .timerPend(timerPend)
    );

    saveRegs #(.NumSave(NumSave)) u_saveRegs (
        .Clk(Clk), .rst(rst), .wEn(wEn), .wAddr(wAddr), .wData(wData),
        .saveVals(saveVals)
    );

    csrReadMux #(.NumSave(NumSave)) u_csrReadMux (
        .rEn(rEn), .rAddr(rAddr), .crmd(crmd), .prmd(prmd), .ecfg(ecfg),
        .estat(estat), .era(eraOut), .eentry(eentryOut), .tid(tid), .tcfg(tcfg),
        .tval(tval), .saveVals(saveVals), .rData(rData)
    );

endmodule

`default_nettype wire

// ==== hw/csrReadMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrReadMux #(
    parameter int NumSave = 4
) (
    input  logic            rEn,
    input  csrPkg::csrAddrT rAddr,
    input  csrPkg::dataT    crmd,
    input  csrPkg::dataT    prmd,
    input  csrPkg::dataT    ecfg,
    input  csrPkg::dataT    estat,
    input  csrPkg::dataT    era,
    input  csrPkg::dataT    eentry,
    input  csrPkg::dataT    tid,
    input  csrPkg::dataT    tcfg,
    input  csrPkg::dataT    tval,
    input  csrPkg::dataT    saveVals [NumSave],
    output csrPkg::dataT    rData
);
    import csrPkg::*;

    localparam int IdxW = (NumSave > 1) ? $clog2(NumSave) : 1;

    csrAddrT saveOff;

    always_comb begin
        saveOff = rAddr - AddrSave0;
        rData = '0;
        if (rEn) begin
            case (rAddr)
                AddrCrmd:   rData = crmd;
                AddrPrmd:   rData = prmd;
                AddrEcfg:   rData = ecfg;
                AddrEstat:  rData = estat;
                AddrEra:    rData = era;
                AddrEentry: rData = eentry;
                AddrTid:    rData = tid;
                AddrTcfg:   rData = tcfg;
                AddrTval:   rData = tval;
                // ticlr is write-only, reads back zero
                AddrTiclr:  rData = '0;
                default: begin
                    if ((rAddr >= AddrSave0) && (saveOff < NumSave)) begin
                        rData = saveVals[saveOff[IdxW-1:0]];
                    end
                end
            endcase
        end
        assert (rEn || (rData == '0))
            else $error("csrReadMux: rData not zero with rEn low");
    end

endmodule

`default_nettype wire

// ==== hw/saveRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module saveRegs #(
    parameter int NumSave = 4
) (
    input  logic            Clk,
    input  logic            rst,
    input  logic            wEn,
    input  csrPkg::csrAddrT wAddr,
    input  csrPkg::dataT    wData,
    output csrPkg::dataT    saveVals [NumSave]
);
    import csrPkg::*;

    logic [NumSave-1:0] hit;

    // one decode per scratch slot
    always_comb begin
        for (int i = 0; i < NumSave; i++) begin
            hit[i] = wEn && (wAddr == csrAddrT'(AddrSave0 + i));
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < NumSave; i++) begin
                saveVals[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumSave; i++) begin
                if (hit[i]) begin
                    saveVals[i] <= wData;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/stableTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stableTimer (
    input  logic            Clk,
    input  logic            rst,
    input  logic            wEn,
    input  csrPkg::csrAddrT wAddr,
    input  csrPkg::dataT    wData,
    output csrPkg::dataT    tid,
    output csrPkg::dataT    tcfg,
    output csrPkg::dataT    tval,
    output logic            timerPend
);
    import csrPkg::*;

    logic tidWr;
    logic tcfgWr;
    logic ticlrWr;
    logic running;
    logic hitZero;
    dataT reloadVal;

    assign tidWr   = wEn && (wAddr == AddrTid);
    assign tcfgWr  = wEn && (wAddr == AddrTcfg);
    assign ticlrWr = wEn && (wAddr == AddrTiclr);

    // counting stops once a one-shot run reaches zero
    assign running   = tcfg[TcfgEn] && (tval != '0);
    assign hitZero   = running && (tval == dataT'(1));
    assign reloadVal = {tcfg[TcfgInitHi:TcfgInitLo], 2'b00};

    always_ff @(posedge Clk) begin
        if (rst) begin
            tid  <= '0;
            tcfg <= '0;
            tval <= '0;
        end else begin
            if (tidWr) begin
                tid <= wData;
            end
            if (tcfgWr) begin
                tcfg <= wData;
                tval <= {wData[TcfgInitHi:TcfgInitLo], 2'b00};
            end else if (hitZero) begin
                tval <= tcfg[TcfgPeriodic] ? reloadVal : '0;
            end else if (running) begin
                tval <= tval - dataT'(1);
            end
        end
    end

    // a new expiry beats a clear in the same cycle
    always_ff @(posedge Clk) begin
        if (rst) begin
            timerPend <= 1'b0;
        end else if (hitZero) begin
            timerPend <= 1'b1;
        end else if (ticlrWr && wData[TiclrClr]) begin
            timerPend <= 1'b0;
        end
    end

    assert property (@(posedge Clk) disable iff (rst)
        !tcfgWr && !(hitZero && tcfg[TcfgPeriodic]) |=> tval <= $past(tval))
        else $error("stableTimer: tval rose without a load or reload");

endmodule

`default_nettype wire

// ==== hw/excCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module excCtrl (
    input  logic            Clk,
    input  logic            rst,
    input  logic            wEn,
    input  csrPkg::csrAddrT wAddr,
    input  csrPkg::dataT    wData,
    trapIf.sink             trap,
    input  csrPkg::hwIrqT   hwIrq,
    input  logic            timerPend,
    input  logic            ie,
    output csrPkg::dataT    ecfg,
    output csrPkg::dataT    estat,
    output csrPkg::dataT    era,
    output csrPkg::dataT    eentry,
    output logic            irqReq
);
    import csrPkg::*;

    logic  trapEntry;
    logic  [1:0] isSw;
    hwIrqT isHw;
    ecodeT ecode;
    esubT  esub;
    isVecT isVec;

    assign trapEntry = trap.valid && !trap.isReturn;

    always_ff @(posedge Clk) begin
        if (rst) begin
            ecfg   <= '0;
            eentry <= '0;
            isSw   <= '0;
            isHw   <= '0;
        end else begin
            // hardware lines are resampled every cycle
            isHw <= hwIrq;
            if (wEn && (wAddr == AddrEcfg)) begin
                ecfg <= {19'd0, wData[12:0]};
            end
            if (wEn && (wAddr == AddrEentry)) begin
                eentry <= {wData[31:6], 6'd0};
            end
            if (wEn && (wAddr == AddrEstat)) begin
                isSw <= wData[1:0];
            end
        end
    end

    // exception info is only written by a trap
    always_ff @(posedge Clk) begin
        if (rst) begin
            era   <= '0;
            ecode <= '0;
            esub  <= '0;
        end else if (trapEntry) begin
            era   <= trap.pc;
            ecode <= trap.ecode;
            esub  <= trap.esub;
        end else if (wEn && (wAddr == AddrEra)) begin
            era <= wData;
        end
    end

    assign isVec = {1'b0, timerPend, 1'b0, isHw, isSw};

    always_comb begin
        estat = '0;
        estat[12:0] = isVec;
        estat[EstatEcodeHi:EstatEcodeLo] = ecode;
        estat[EstatEsubHi:EstatEsubLo] = esub;
    end

    assign irqReq = (|(ecfg[12:0] & isVec)) && ie;

    assert property (@(posedge Clk) disable iff (rst) irqReq |-> ie)
        else $error("excCtrl: irqReq raised with ie clear");

endmodule

`default_nettype wire

// ==== hw/privCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module privCtrl (
    input  logic            Clk,
    input  logic            rst,
    input  logic            wEn,
    input  csrPkg::csrAddrT wAddr,
    input  csrPkg::dataT    wData,
    trapIf.sink             trap,
    output csrPkg::dataT    crmd,
    output csrPkg::dataT    prmd
);
    import csrPkg::*;

    logic trapEntry;
    logic trapRet;
    logic crmdWr;
    logic prmdWr;

    assign trapEntry = trap.valid && !trap.isReturn;
    assign trapRet   = trap.valid && trap.isReturn;
    assign crmdWr    = wEn && (wAddr == AddrCrmd);
    assign prmdWr    = wEn && (wAddr == AddrPrmd);

    // trap and ertn take priority over a software write
    always_ff @(posedge Clk) begin
        if (rst) begin
            crmd <= '0;
            crmd[CrmdDa] <= 1'b1;
        end else if (trapEntry) begin
            crmd[CrmdPlvHi:CrmdPlvLo] <= '0;
            crmd[CrmdIe] <= 1'b0;
        end else if (trapRet) begin
            crmd[CrmdPlvHi:CrmdPlvLo] <= prmd[CrmdPlvHi:CrmdPlvLo];
            crmd[CrmdIe] <= prmd[CrmdIe];
        end else if (crmdWr) begin
            crmd <= '0;
            crmd[CrmdPlvHi:CrmdPlvLo] <= wData[CrmdPlvHi:CrmdPlvLo];
            crmd[CrmdIe] <= wData[CrmdIe];
            crmd[CrmdDa] <= wData[CrmdDa];
            crmd[CrmdPg] <= wData[CrmdPg];
        end
    end

    // prmd only holds pplv and pie
    always_ff @(posedge Clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (trapEntry) begin
            prmd[CrmdPlvHi:CrmdPlvLo] <= crmd[CrmdPlvHi:CrmdPlvLo];
            prmd[CrmdIe] <= crmd[CrmdIe];
        end else if (prmdWr) begin
            prmd <= '0;
            prmd[CrmdPlvHi:CrmdPlvLo] <= wData[CrmdPlvHi:CrmdPlvLo];
            prmd[CrmdIe] <= wData[CrmdIe];
        end
    end

    // entry drops to kernel with interrupts off
    assert property (@(posedge Clk) disable iff (rst)
        trapEntry |=> (crmd[CrmdIe] == 1'b0) && (crmd[CrmdPlvHi:CrmdPlvLo] == '0))
        else $error("privCtrl: crmd plv/ie not cleared after trap entry");

endmodule

`default_nettype wire

// ==== hw/trapIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface trapIf;
    import csrPkg::*;

    logic  valid;
    logic  isReturn;
    dataT  pc;
    ecodeT ecode;
    esubT  esub;

    // driven from the top-level trap ports
    modport src (
        output valid, isReturn, pc, ecode, esub
    );

    modport sink (
        input valid, isReturn, pc, ecode, esub
    );

endinterface

`default_nettype wire

// ==== hw/csrPkg.sv ====
`default_nettype none

package csrPkg;

    // plain vectors with a meaning of their own
    typedef logic [31:0] dataT;
    typedef logic [13:0] csrAddrT;
    typedef logic [1:0]  plvT;
    typedef logic [5:0]  ecodeT;
    typedef logic [8:0]  esubT;
    typedef logic [7:0]  hwIrqT;

    // 1:0 software, 9:2 hardware, 10 unused, 11 timer, 12 reserved
    typedef logic [12:0] isVecT;

    // csr numbers
    localparam csrAddrT AddrCrmd   = 14'h0;
    localparam csrAddrT AddrPrmd   = 14'h1;
    localparam csrAddrT AddrEcfg   = 14'h4;
    localparam csrAddrT AddrEstat  = 14'h5;
    localparam csrAddrT AddrEra    = 14'h6;
    localparam csrAddrT AddrEentry = 14'hc;
    localparam csrAddrT AddrSave0  = 14'h30;
    localparam csrAddrT AddrTid    = 14'h40;
    localparam csrAddrT AddrTcfg   = 14'h41;
    localparam csrAddrT AddrTval   = 14'h42;
    localparam csrAddrT AddrTiclr  = 14'h44;

    // crmd fields, prmd reuses plv and ie positions
    localparam int CrmdPlvLo = 0;
    localparam int CrmdPlvHi = 1;
    localparam int CrmdIe    = 2;
    localparam int CrmdDa    = 3;
    localparam int CrmdPg    = 4;

    // tcfg fields
    localparam int TcfgEn       = 0;
    localparam int TcfgPeriodic = 1;
    localparam int TcfgInitLo   = 2;
    localparam int TcfgInitHi   = 31;

    // estat fields
    localparam int EstatEcodeLo = 16;
    localparam int EstatEcodeHi = 21;
    localparam int EstatEsubLo  = 22;
    localparam int EstatEsubHi  = 30;

    // ticlr clear bit
    localparam int TiclrClr = 0;

    localparam int DefNumSave = 4;

endpackage

`default_nettype wire
